// ==== build.f ====
src/sensi2c_pkg.sv
src/i2c_byte_if.sv
src/ctrl_decode.sv
src/cmd_fifo.sv
src/byte_sequencer.sv
src/bit_engine.sv
src/sensor_i2c_top.sv
verification/bit_engine_sva.sv
verification/tb_sensor_i2c.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, exit status carries the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sensor_i2c -Mdir obj_dir -f build.f &&
./obj_dir/Vtb_sensor_i2c ||
{ echo "simulation did not pass"; exit 1; }

// ==== src/bit_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_engine
    import sensi2c_pkg::*;
(
    input  logic         mclk,
    input  logic         reset_cmd,
    input  quarter_dly_t quarter_dly,
    i2c_byte_if.snk      byte_i,
    output logic         scl,           // push-pull
    output logic         sda_drive_low  // open drain pull-down
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1; // 3 quarters
    localparam logic [1:0] ST_DATA  = 2'd2; // 9 bits of 4 quarters
    localparam logic [1:0] ST_STOP  = 2'd3; // 3 quarters

    logic [1:0]   state;
    logic [1:0]   qtr;       // quarter inside start, bit or stop
    logic [3:0]   bit_idx;   // 0..7 data, 8 ack
    quarter_dly_t dly_cnt;   // quarter down counter
    logic [8:0]   sr;        // byte plus released ack bit
    logic         last_r;    // byte in flight ends the word
    logic         have_next; // next byte already taken during ack
    logic         qend;      // last cycle of a quarter
    logic         ack_slot;
    logic         xfer;

    assign qend     = (dly_cnt == quarter_dly_t'(1));
    assign ack_slot = (bit_idx == 4'd8);
    assign xfer     = byte_i.valid && byte_i.ready;

    // next byte only in the last ack quarter of a non-last byte
    assign byte_i.ready = (state == ST_IDLE) ||
                          ((state == ST_DATA) && ack_slot && (qtr == 2'd3) &&
                           !last_r && !have_next);

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            dly_cnt <= DLY_DEFAULT;
        end else if ((state == ST_IDLE) || qend) begin
            dly_cnt <= quarter_dly; // delay picked up at every quarter
        end else begin
            dly_cnt <= dly_cnt - 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            state     <= ST_IDLE;
            qtr       <= 2'd0;
            bit_idx   <= 4'd0;
            last_r    <= 1'b0;
            have_next <= 1'b0;
        end else begin
            if (xfer) begin
                last_r <= byte_i.last;
            end
            case (state)
                ST_IDLE: begin
                    if (xfer && byte_i.first) begin // address byte opens the word
                        state   <= ST_START;
                        qtr     <= 2'd0;
                        bit_idx <= 4'd0;
                    end
                end
                ST_START: begin
                    if (qend && (qtr == 2'd2)) begin
                        state <= ST_DATA;
                        qtr   <= 2'd0;
                    end else if (qend) begin
                        qtr <= qtr + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (xfer) begin
                        have_next <= 1'b1;
                    end
                    if (qend) begin
                        if (qtr != 2'd3) begin
                            qtr <= qtr + 1'b1;
                        end else if (!ack_slot) begin
                            qtr     <= 2'd0;
                            bit_idx <= bit_idx + 1'b1;
                        end else if (have_next || xfer) begin
                            qtr       <= 2'd0; // straight into the next byte
                            bit_idx   <= 4'd0;
                            have_next <= 1'b0;
                        end else if (last_r) begin
                            state <= ST_STOP;
                            qtr   <= 2'd0;
                        end
                        // else scl stays low until the sequencer catches up
                    end
                end
                default: begin // ST_STOP
                    if (qend && (qtr == 2'd2)) begin
                        state <= ST_IDLE;
                        qtr   <= 2'd0;
                    end else if (qend) begin
                        qtr <= qtr + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (xfer) begin
            sr <= {byte_i.data, 1'b1}; // trailing 1 releases sda in the ack slot
        end else if ((state == ST_DATA) && qend && (qtr == 2'd3) && !ack_slot) begin
            sr <= {sr[7:0], 1'b1};
        end
    end

    // outputs follow the quarter state one cycle later, quarter lengths unchanged
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    scl           <= 1'b1;
                    sda_drive_low <= 1'b0;
                end
                ST_START: begin
                    scl           <= (qtr != 2'd2);    // h h l
                    sda_drive_low <= (qtr != 2'd0);    // sda falls under high scl
                end
                ST_DATA: begin
                    scl <= (qtr == 2'd1) || (qtr == 2'd2); // l h h l
                    if (qtr == 2'd0) begin
                        sda_drive_low <= !sr[8];       // only change while scl low
                    end
                end
                default: begin // ST_STOP
                    scl           <= (qtr != 2'd0);    // l h h
                    sda_drive_low <= (qtr != 2'd2);    // sda rises under high scl
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/byte_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_sequencer
    import sensi2c_pkg::*;
(
    input  logic          mclk,
    input  logic          reset_cmd,
    input  logic          run_en,
    input  byte_cnt_t     byte_cnt,   // data bytes after the address
    input  logic          head_valid,
    input  cmd_word_t     head_word,
    output logic          head_ready,
    i2c_byte_if.src       byte_o
);

    logic      busy;    // a word is being sent
    logic      first_r; // address byte still pending
    byte_cnt_t left;    // data bytes after the current one
    cmd_word_t word_r;  // current byte sits in the top slot
    logic      pop;
    logic      xfer;

    assign head_ready = !busy && run_en;
    assign pop        = head_valid && head_ready;
    assign xfer       = byte_o.valid && byte_o.ready;

    assign byte_o.valid = busy;
    assign byte_o.data  = word_r.slave_addr;
    assign byte_o.first = first_r;
    assign byte_o.last  = (left == '0);

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            busy    <= 1'b0;
            first_r <= 1'b0;
            left    <= '0;
        end else if (pop) begin
            busy    <= 1'b1;
            first_r <= 1'b1;
            left    <= byte_cnt; // count is frozen for this word
        end else if (xfer) begin
            first_r <= 1'b0;
            if (left == '0) begin
                busy <= 1'b0;    // word done, free for the next pop
            end else begin
                left <= left - 1'b1;
            end
        end
    end

    // msb first, shift the next byte up after each transfer
    always_ff @(posedge mclk) begin
        if (pop) begin
            word_r <= head_word;
        end else if (xfer) begin
            word_r <= {word_r.data2, word_r.data1, word_r.data0, 8'h00};
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo
    import sensi2c_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic      mclk,
    input  logic      reset_cmd,
    input  logic      fifo_clear, // empties the buffer, wins over a write
    input  logic      cmd_valid,
    input  cmd_word_t cmd_word,
    output logic      cmd_ready,
    output logic      head_valid,
    output cmd_word_t head_word,
    input  logic      head_ready
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    cmd_word_t                mem [DEPTH];
    logic [FIFO_DEPTH_LOG2:0] wr_ptr; // extra msb tells full from empty
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;
    logic                     full;
    logic                     push;
    logic                     pop;

    // same address, different wrap bit
    assign full = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                  (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign cmd_ready  = !full;              // host back-pressure
    assign head_valid = (wr_ptr != rd_ptr);
    assign head_word  = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]]; // visible right after the write

    assign push = cmd_valid && !full;
    assign pop  = head_valid && head_ready;

    always_ff @(posedge mclk) begin
        if (reset_cmd || fifo_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (push) begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= cmd_word; // stale slot after a clear is harmless
        end
    end

endmodule

`default_nettype wire

// ==== src/ctrl_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_decode
    import sensi2c_pkg::*;
(
    input  logic         mclk,
    input  logic         reset_cmd,
    input  logic         wr_valid,
    input  logic         wr_ctrl,     // word is a control word
    input  host_word_u   wr_data,
    output logic         wr_ready,
    output logic         cmd_valid,
    output cmd_word_t    cmd_word,
    input  logic         cmd_ready,
    output logic         fifo_clear,  // one cycle pulse
    output logic         run_en,
    output byte_cnt_t    byte_cnt,
    output quarter_dly_t quarter_dly
);

    ctrl_word_t ctrl;     // host word seen as control
    logic       ctrl_acc; // control word taken this cycle

    assign ctrl     = wr_data.ctrl;
    assign ctrl_acc = wr_valid && wr_ctrl; // control words never stall

    // commands go straight through to the FIFO
    assign wr_ready  = wr_ctrl || cmd_ready;
    assign cmd_valid = wr_valid && !wr_ctrl;
    assign cmd_word  = wr_data.cmd;

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            fifo_clear  <= 1'b0;
            run_en      <= 1'b0;          // sequencer stopped after reset
            byte_cnt    <= BYTES_DEFAULT;
            quarter_dly <= DLY_DEFAULT;
        end else begin
            fifo_clear <= ctrl_acc && ctrl.fifo_clear;
            if (ctrl_acc && ctrl.run_set) begin
                run_en <= ctrl.run_val;
            end
            if (ctrl_acc && ctrl.bytes_set) begin
                byte_cnt <= ctrl.bytes;
            end
            if (ctrl_acc && ctrl.dly_set) begin
                // the bit engine needs at least two cycles per quarter
                quarter_dly <= (ctrl.dly < DLY_MIN) ? DLY_MIN : ctrl.dly;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/i2c_byte_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// framed bytes from sequencer to bit engine, valid/ready handshake
interface i2c_byte_if;
    logic       valid; // byte offered, held until taken
    logic [7:0] data;
    logic       first; // slave address byte
    logic       last;  // final byte of the command word
    logic       ready; // engine can take a byte

    modport src (output valid, data, first, last, input ready);
    modport snk (input valid, data, first, last, output ready);

endinterface

`default_nettype wire

// ==== src/sensi2c_pkg.sv ====
`default_nettype none

package sensi2c_pkg;

    localparam int WORD_W  = 32; // host word
    localparam int DLY_W   = 8;  // quarter delay field
    localparam int BYTES_W = 2;  // data bytes after slave address

    typedef logic [BYTES_W-1:0] byte_cnt_t;    // 0..3 data bytes
    typedef logic [DLY_W-1:0]   quarter_dly_t; // mclk cycles per quarter bit

    localparam quarter_dly_t DLY_DEFAULT   = 8'h64; // nominal 100 cycles
    localparam byte_cnt_t    BYTES_DEFAULT = 2'd3;
    localparam quarter_dly_t DLY_MIN       = 8'd2;  // smaller writes are held here

    // command word, slave address goes out first
    typedef struct packed {
        logic [7:0] slave_addr; // [31:24]
        logic [7:0] data2;
        logic [7:0] data1;
        logic [7:0] data0;      // [7:0], last on the wire
    } cmd_word_t;

    // control word, each field applies only with its set bit
    typedef struct packed {
        logic [WORD_W-16:0] rsvd;       // [31:15]
        logic               fifo_clear; // [14] drop all pending commands
        logic               run_set;    // [13]
        logic               run_val;    // [12]
        logic               bytes_set;  // [11]
        byte_cnt_t          bytes;      // [10:9]
        logic               dly_set;    // [8]
        quarter_dly_t       dly;        // [7:0]
    } ctrl_word_t;

    // one host word, meaning selected by wr_ctrl
    typedef union packed {
        cmd_word_t  cmd;
        ctrl_word_t ctrl;
    } host_word_u;

endpackage

`default_nettype wire

// ==== src/sensor_i2c_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sensor_i2c_top
    import sensi2c_pkg::*;
(
    input  logic       mclk,
    input  logic       reset_cmd,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  logic       wr_ctrl,       // 1 control word, 0 command word
    input  host_word_u wr_data,
    output logic       scl,
    output logic       sda_drive_low  // sda line is low when set
);

    logic         cmd_valid;
    logic         cmd_ready;
    cmd_word_t    cmd_word;
    logic         fifo_clear;
    logic         run_en;
    byte_cnt_t    byte_cnt;
    quarter_dly_t quarter_dly;
    logic         head_valid;
    logic         head_ready;
    cmd_word_t    head_word;

    i2c_byte_if byte_bus ();

    ctrl_decode u_ctrl_decode (
        .mclk        (mclk),
        .reset_cmd   (reset_cmd),
        .wr_valid    (wr_valid),
        .wr_ctrl     (wr_ctrl),
        .wr_data     (wr_data),
        .wr_ready    (wr_ready),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .cmd_ready   (cmd_ready),
        .fifo_clear  (fifo_clear),
        .run_en      (run_en),
        .byte_cnt    (byte_cnt),
        .quarter_dly (quarter_dly)
    );

    cmd_fifo #(
        .FIFO_DEPTH_LOG2 (3)  // 8 commands
    ) u_cmd_fifo (
        .mclk       (mclk),
        .reset_cmd  (reset_cmd),
        .fifo_clear (fifo_clear),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_ready  (cmd_ready),
        .head_valid (head_valid),
        .head_word  (head_word),
        .head_ready (head_ready)
    );

    byte_sequencer u_byte_sequencer (
        .mclk       (mclk),
        .reset_cmd  (reset_cmd),
        .run_en     (run_en),
        .byte_cnt   (byte_cnt),
        .head_valid (head_valid),
        .head_word  (head_word),
        .head_ready (head_ready),
        .byte_o     (byte_bus.src)
    );

    bit_engine u_bit_engine (
        .mclk          (mclk),
        .reset_cmd     (reset_cmd),
        .quarter_dly   (quarter_dly),
        .byte_i        (byte_bus.snk),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

// ==== verification/bit_engine_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_engine_sva (
    input logic       mclk,
    input logic       reset_cmd,
    input logic       idle,   // engine FSM in idle
    input logic       scl,
    input logic       sda_drive_low,
    input logic       valid,
    input logic [7:0] data,
    input logic       first,
    input logic       last,
    input logic       ready
);

    // bus released one cycle after reset
    reset_bus_free: assert property (@(posedge mclk) reset_cmd |=> (scl && !sda_drive_low))
        else $error("bus not released after reset");

    // offered byte waits unchanged until taken
    byte_held: assert property (@(posedge mclk) disable iff (reset_cmd)
        (valid && !ready) |=> (valid && $stable(data) && $stable(first) && $stable(last)))
        else $error("byte changed before the handshake");

    idle_scl_high: assert property (@(posedge mclk) disable iff (reset_cmd) idle |-> scl)
        else $error("scl low while the engine is idle");

endmodule

bind bit_engine bit_engine_sva u_bit_engine_sva (
    .mclk          (mclk),
    .reset_cmd     (reset_cmd),
    .idle          (state == ST_IDLE),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .valid         (byte_i.valid),
    .data          (byte_i.data),
    .first         (byte_i.first),
    .last          (byte_i.last),
    .ready         (byte_i.ready)
);

`default_nettype wire

// ==== verification/tb_sensor_i2c.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sensor_i2c
    import sensi2c_pkg::*;
;

    localparam int IDLE_WAIT   = 200;                    // quiet window, bus must stay idle
    localparam int TXN_MAX_CYC = (3 + 4 * 9 * 4 + 3) * 4; // start, 4 bytes of 9 bits, stop, dly 4
    localparam int TXN_COUNT   = 6;                      // 3 + 2 + 1 transactions in the test list
    localparam int TIMEOUT_CYC = 2 * (TXN_COUNT * TXN_MAX_CYC + 2 * IDLE_WAIT);

    logic       mclk;
    logic       reset_cmd;
    logic       wr_valid;
    logic       wr_ready;
    logic       wr_ctrl;
    host_word_u wr_data;
    logic       scl;
    logic       sda_drive_low;

    logic [31:0] rng;
    int          cycle_cnt;

    // monitor state and its records
    logic        scl_prev;
    logic        sda_prev;
    logic        sda_now;
    logic [8:0]  shreg;       // 8 data bits plus ack
    int          bit_cnt;
    int          hi_cnt;      // cycles scl has been high
    logic        hi_ok;       // high period opened by a data bit rise
    int          start_cnt = 0;
    logic [7:0]  cur_bytes [$];
    logic [7:0]  rx_bytes [$]; // all bytes, in bus order
    int          rx_len [$];   // bytes per transaction
    int          hi_q [$];     // scl high time of each data bit
    int          rx_rd = 0;    // next unchecked transaction
    int          byte_rd = 0;

    sensor_i2c_top i_dut (
        .mclk          (mclk),
        .reset_cmd     (reset_cmd),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_ctrl       (wr_ctrl),
        .wr_data       (wr_data),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp_val);
            end_with_failure();
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp_val);
        if (got !== exp_val) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp_val);
            end_with_failure();
        end
    endtask

    task automatic compare_word(input string name, input cmd_word_t got, input cmd_word_t exp_val);
        if (got !== exp_val) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp_val);
            end_with_failure();
        end
    endtask

    task automatic compare_count(input string name, input byte_cnt_t got, input byte_cnt_t exp_val);
        if (got !== exp_val) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp_val);
            end_with_failure();
        end
    endtask

    // scl high per bit is two quarters
    task automatic compare_dly(input string name, input int measured, input quarter_dly_t dly);
        int exp_hi;
        exp_hi = 2 * int'(dly);
        if (measured != exp_hi) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, measured, exp_hi);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic cmd_word_t next_cmd();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic host_word_u make_ctrl(input logic clr, input logic run_set,
                                             input logic run_val, input logic bytes_set,
                                             input byte_cnt_t bytes, input logic dly_set,
                                             input quarter_dly_t dly);
        host_word_u w;
        w                = '0;
        w.ctrl.fifo_clear = clr;
        w.ctrl.run_set   = run_set;
        w.ctrl.run_val   = run_val;
        w.ctrl.bytes_set = bytes_set;
        w.ctrl.bytes     = bytes;
        w.ctrl.dly_set   = dly_set;
        w.ctrl.dly       = dly;
        return w;
    endfunction

    // called 5 ns after a rising edge, returns at the same phase
    task automatic write_word(input logic is_ctrl, input host_word_u w);
        logic took;
        wr_valid = 1'b1;
        wr_ctrl  = is_ctrl;
        wr_data  = w;
        do begin
            @(negedge mclk);
            took = wr_ready;   // word moves on the next edge
            @(posedge mclk);
            #5;
        end while (!took);
        wr_valid = 1'b0;
    endtask

    task automatic write_cmd(input cmd_word_t c);
        host_word_u w;
        w.cmd = c;
        write_word(1'b0, w);
    endtask

    // clear pulse lands one cycle late, keep the next write clear of it
    task automatic clear_fifo();
        write_word(1'b1, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 8'd0));
        @(posedge mclk);
        #5;
    endtask

    task automatic wait_txns(input int n);
        while (rx_len.size() < rx_rd + n) begin
            @(posedge mclk);
            #5;
        end
    endtask

    // next bus record, length against the count, unsent low bytes read as zero
    task automatic check_txn(input byte_cnt_t n, output cmd_word_t got);
        logic [31:0] got_v;
        int          len;
        int          i;
        len = rx_len[rx_rd];
        rx_rd++;
        if (len < 1 || len > 4) begin
            $display("transaction %0d carried %0d bytes", rx_rd, len);
            end_with_failure();
        end
        compare_count("data_bytes", byte_cnt_t'(len - 1), n);
        got_v = '0;
        for (i = 0; i < len; i++) begin
            got_v[31 - 8 * i -: 8] = rx_bytes[byte_rd]; // msb first on the wire
            byte_rd++;
        end
        got = got_v;
    endtask

    // bus monitor at mid cycle, registered outputs are settled here
    always @(negedge mclk) begin
        sda_now = !sda_drive_low; // open drain line with pull-up
        if (reset_cmd) begin
            scl_prev = 1'b1;
            sda_now  = 1'b1;
            bit_cnt  = 0;
            hi_ok    = 1'b0;
        end else begin
            if (scl_prev && scl && sda_prev && !sda_now) begin // start
                start_cnt++;
                bit_cnt = 0;
                hi_ok   = 1'b0;
                cur_bytes.delete();
            end else if (scl_prev && scl && !sda_prev && sda_now) begin // stop
                // the scl rise that opens a stop is counted as one bit
                if (bit_cnt != 1) begin
                    $display("stop condition in the middle of a byte");
                    end_with_failure();
                end
                rx_len.push_back(cur_bytes.size());
                foreach (cur_bytes[k]) begin
                    rx_bytes.push_back(cur_bytes[k]);
                end
                bit_cnt = 0;
            end
            if (!scl_prev && scl) begin
                shreg = {shreg[7:0], sda_now};
                bit_cnt++;
                hi_cnt = 1;
                hi_ok  = 1'b1;
                if (bit_cnt == 9) begin
                    compare_bit("sda ack slot", shreg[0], 1'b1); // released
                    cur_bytes.push_back(shreg[8:1]);
                    bit_cnt = 0;
                end
            end else if (scl_prev && scl) begin
                hi_cnt++;
            end else if (scl_prev && !scl && hi_ok) begin
                hi_q.push_back(hi_cnt);
            end
        end
        scl_prev = scl;
        sda_prev = sda_now;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge mclk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYC) begin
                $display("timeout, tests still running after %0d cycles", cycle_cnt);
                end_with_failure();
            end
        end
    end

    task automatic test_reset_idle();
        @(negedge mclk);
        compare_bit("scl", scl, 1'b1);
        compare_bit("sda_drive_low", sda_drive_low, 1'b0);
        @(posedge mclk);
        #5;
        write_cmd(next_cmd()); // run is off after reset
        repeat (IDLE_WAIT) @(posedge mclk);
        #5;
        if (start_cnt != 0) begin
            $display("bus transaction started while run was off");
            end_with_failure();
        end
        clear_fifo();
    endtask

    task automatic test_full_words();
        cmd_word_t sent [3];
        cmd_word_t got;
        int        hi_base;
        int        i;
        hi_base = hi_q.size();
        write_word(1'b1, make_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 2'd3, 1'b1, 8'd4));
        for (i = 0; i < 3; i++) begin
            sent[i] = next_cmd();
            write_cmd(sent[i]);
        end
        write_word(1'b1, make_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 1'b0, 8'd0)); // run
        wait_txns(3);
        for (i = 0; i < 3; i++) begin
            check_txn(2'd3, got);
            compare_word("cmd_word", got, sent[i]);
        end
        if (hi_q.size() == hi_base) begin
            $display("no scl high time was measured");
            end_with_failure();
        end
        for (i = hi_base; i < hi_q.size(); i++) begin
            compare_dly("scl high cycles", hi_q[i], 8'd4);
        end
    endtask

    task automatic test_byte_count();
        cmd_word_t   c;
        cmd_word_t   got;
        byte_cnt_t   n;
        logic [31:0] got_v;
        logic [31:0] exp_v;
        int          k;
        int          i;
        for (k = 0; k < 2; k++) begin
            n = (k == 0) ? 2'd0 : 2'd2;
            write_word(1'b1, make_ctrl(1'b0, 1'b0, 1'b0, 1'b1, n, 1'b0, 8'd0));
            c = next_cmd();
            write_cmd(c);
            wait_txns(1);
            check_txn(n, got);
            got_v = got;
            exp_v = c;     // slave address in the top byte
            for (i = 0; i <= int'(n); i++) begin // top n+1 bytes only
                compare_byte($sformatf("sda byte %0d", i), got_v[31 - 8 * i -: 8],
                             exp_v[31 - 8 * i -: 8]);
            end
        end
    endtask

    task automatic test_backpressure();
        host_word_u w;
        int         starts;
        int         i;
        write_word(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, 8'd0)); // stop
        starts = start_cnt;
        for (i = 0; i < 8; i++) begin
            write_cmd(next_cmd());
        end
        w.cmd    = next_cmd();
        wr_valid = 1'b1;           // ninth command finds the FIFO full
        wr_ctrl  = 1'b0;
        wr_data  = w;
        @(negedge mclk);
        compare_bit("wr_ready", wr_ready, 1'b0);
        @(posedge mclk);
        #5;
        wr_ctrl = 1'b1;            // control word still goes through
        wr_data = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 8'd0);
        @(negedge mclk);
        compare_bit("wr_ready", wr_ready, 1'b1);
        @(posedge mclk);
        #5;
        wr_valid = 1'b0;
        wr_ctrl  = 1'b0;
        @(posedge mclk);           // pointers reset on this edge
        @(negedge mclk);
        compare_bit("wr_ready", wr_ready, 1'b1);
        @(posedge mclk);
        #5;
        if (start_cnt != starts) begin
            $display("bus transaction started while run was off");
            end_with_failure();
        end
    endtask

    task automatic test_clear_pending();
        cmd_word_t keep;
        cmd_word_t got;
        int        starts;
        int        i;
        for (i = 0; i < 3; i++) begin
            write_cmd(next_cmd());
        end
        clear_fifo();
        keep = next_cmd();
        write_cmd(keep);
        starts = start_cnt;
        write_word(1'b1, make_ctrl(1'b0, 1'b1, 1'b1, 1'b1, 2'd3, 1'b0, 8'd0));
        wait_txns(1);
        repeat (IDLE_WAIT) @(posedge mclk);
        #5;
        if (start_cnt != starts + 1) begin
            $display("cleared commands reached the bus");
            end_with_failure();
        end
        check_txn(2'd3, got);
        compare_word("cmd_word", got, keep);
    endtask

    initial begin
        reset_cmd = 1'b1;
        wr_valid  = 1'b0;
        wr_ctrl   = 1'b0;
        wr_data   = '0;
        rng       = 32'd45;
        repeat (2) @(posedge mclk);
        #5;
        reset_cmd = 1'b0;
        test_reset_idle();
        test_full_words();
        test_byte_count();
        test_backpressure();
        test_clear_pending();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
